// File: ddr3_write_bridge.f
design/axi_wr_pkg.sv
design/ddr_wr_pkg.sv
design/wr_ctrl_fsm.sv
design/pad_counter.sv
design/burst_splitter.sv
design/wide_pack_fifo.sv
design/ddr3_write_bridge.sv
verif/ddr_port_model.sv
verif/tb_ddr3_write_bridge.sv

// File: verif/tb_ddr3_write_bridge.sv
`timescale 1ns/100ps

module tb_ddr3_write_bridge;
    import axi_wr_pkg::*;
    import ddr_wr_pkg::*;

    localparam int total_words = 8 + 6 + 256 + 100 + 8 + 16;
    localparam int cycle_limit = 20 * total_words + 1000;   // generous even with random gaps

    logic        clk;
    logic        rstn;
    axi_aw_t     s_aw;
    logic        s_aw_valid;
    logic        s_aw_ready;
    axi_w_t      s_w;
    logic        s_w_valid;
    logic        s_w_ready;
    axi_b_t      s_b;
    logic        s_b_valid;
    logic        s_b_ready;
    ddr_cmd_t    ddr_cmd;
    logic        ddr_cmd_valid;
    logic        ddr_cmd_ready;
    ddr_wdata_t  ddr_wdata;
    logic        ddr_data_ready;
    logic        ddr_data_last;
    logic        ddr_delays;
    int          value_errors;
    int          other_errors;
    int          cycles;
    logic [31:0] wdata_q[$];
    logic [3:0]  wstrb_q[$];
    ddr_cmd_t    exp_cmd_q[$];
    ddr_wdata_t  exp_beat_q[$];

    ddr3_write_bridge uut (.*);

    ddr_port_model ddr (
        .clk, .rstn, .delay_en(ddr_delays),
        .cmd(ddr_cmd), .cmd_valid(ddr_cmd_valid), .cmd_ready(ddr_cmd_ready),
        .wdata(ddr_wdata), .data_ready(ddr_data_ready), .data_last(ddr_data_last)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: run still busy after %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_cmd(input ddr_cmd_t got, input ddr_cmd_t exp, input int idx);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: command %0d got addr %h len %0d id %h, expected %h %0d %h",
                     $time, idx, got.addr, got.len, got.id, exp.addr, exp.len, exp.id);
        end
    endtask

    task automatic check_beat(input ddr_wdata_t got, input ddr_wdata_t exp, input int idx);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: beat %0d got strb %h data %h", $time, idx, got.strb, got.data);
            $display("[ERROR] %0t: beat %0d expected strb %h data %h",
                     $time, idx, exp.strb, exp.data);
        end
    endtask

    task automatic check_resp(input axi_b_t got, input axi_b_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: response got id %h resp %s, expected id %h resp %s",
                     $time, got.id, got.resp.name(), exp.id, exp.resp.name());
        end
    endtask

    task automatic fill_words(input int n);
        wdata_q.delete();
        wstrb_q.delete();
        repeat (n) begin
            wdata_q.push_back($urandom);
            wstrb_q.push_back(4'hf);
        end
    endtask

    // padded beats and commands of at most 16 beats
    task automatic build_expected(input logic [3:0] tid, input logic [27:0] addr, input int n);
        int          lane;
        int          nbeats;
        int          left;
        int          b;
        int          l;
        int          j;
        ddr_wdata_t  beat;
        ddr_cmd_t    c;
        logic [27:0] base;
        lane   = addr % 8;
        nbeats = (lane + n + 7) / 8;
        exp_beat_q.delete();
        exp_cmd_q.delete();
        for (b = 0; b < nbeats; b++) begin
            beat = '0;
            for (l = 0; l < 8; l++) begin
                j = b * 8 + l - lane;             // word index, outside 0..n-1 is padding
                if (j >= 0 && j < n) begin
                    beat.data[32*l +: 32] = wdata_q[j];
                    beat.strb[4*l +: 4]   = wstrb_q[j];
                end
            end
            exp_beat_q.push_back(beat);
        end
        base = addr - lane;
        left = nbeats;
        while (left > 0) begin
            c.addr = base;
            c.len  = (left > 16) ? 4'd15 : 4'(left - 1);
            c.id   = tid;
            exp_cmd_q.push_back(c);
            base = base + 28'd128;
            left = left - 16;
        end
    endtask

    task automatic run_write(input logic [3:0] tid, input logic [27:0] addr, input burst_e burst,
                             input bit gaps, input int b_wait);
        int     n;
        int     k;
        axi_b_t got_b;
        axi_b_t exp_b;
        n = wdata_q.size();
        build_expected(tid, addr, n);
        ddr.cmd_q.delete();
        ddr.beat_q.delete();
        s_aw.id    = tid;
        s_aw.addr  = addr;
        s_aw.len   = 8'(n - 1);
        s_aw.burst = burst;
        s_aw_valid = 1'b1;
        while (!s_aw_ready) @(negedge clk);
        @(negedge clk);
        s_aw_valid = 1'b0;
        for (k = 0; k < n; k++) begin
            if (gaps) repeat ($urandom_range(2, 0)) @(negedge clk);
            s_w.data  = wdata_q[k];
            s_w.strb  = wstrb_q[k];
            s_w.last  = (k == n - 1);
            s_w_valid = 1'b1;
            while (!s_w_ready) @(negedge clk);   // ready is registered, stable here
            @(negedge clk);
            s_w_valid = 1'b0;
        end
        while (!s_b_valid) @(negedge clk);
        repeat (b_wait) begin
            @(negedge clk);
            if (!s_b_valid) begin
                other_errors++;
                $display("s_b_valid dropped at %0t before s_b_ready was given", $time);
            end
        end
        s_b_ready = 1'b1;
        got_b     = s_b;
        @(negedge clk);
        s_b_ready  = 1'b0;
        exp_b.id   = tid;
        exp_b.resp = (burst == BURST_INCR) ? RESP_OKAY : RESP_SLVERR;
        check_resp(got_b, exp_b);
        if (!s_aw_ready) begin
            other_errors++;
            $display("s_aw_ready not back the cycle after the response at %0t", $time);
        end
        if (ddr.cmd_q.size() != exp_cmd_q.size() || ddr.beat_q.size() != exp_beat_q.size()) begin
            other_errors++;
            $display("transfer count wrong: %0d commands and %0d beats, expected %0d and %0d",
                     ddr.cmd_q.size(), ddr.beat_q.size(), exp_cmd_q.size(), exp_beat_q.size());
        end else begin
            foreach (exp_cmd_q[i]) check_cmd(ddr.cmd_q[i], exp_cmd_q[i], i);
            foreach (exp_beat_q[i]) check_beat(ddr.beat_q[i], exp_beat_q[i], i);
        end
    endtask

    task automatic test_aligned_incr();
        fill_words(8);
        run_write(4'h3, 28'h0000100, BURST_INCR, 1'b0, 0);
    endtask

    task automatic test_unaligned_short();
        fill_words(6);
        run_write(4'h5, 28'h0000203, BURST_INCR, 1'b0, 0);   // lane 3, two beats
    endtask

    task automatic test_long_split();
        fill_words(256);
        run_write(4'h7, 28'h0001005, BURST_INCR, 1'b0, 0);   // 33 beats as 16, 16, 1
    endtask

    task automatic test_random_delays();
        ddr_delays = 1'b1;
        fill_words(100);
        run_write(4'h9, 28'h0002002, BURST_INCR, 1'b1, 6);
        ddr_delays = 1'b0;
    endtask

    task automatic test_wrap_slverr();
        fill_words(8);
        run_write(4'hb, 28'h0003004, BURST_WRAP, 1'b0, 0);
    endtask

    task automatic test_partial_strobes();
        fill_words(16);
        wstrb_q[1]  = 4'b0001;
        wstrb_q[6]  = 4'b1010;
        wstrb_q[15] = 4'b0110;
        run_write(4'hd, 28'h0004002, BURST_INCR, 1'b0, 1);
    endtask

    initial begin
        void'($urandom(67632));
        rstn       = 1'b0;
        s_aw       = '0;
        s_aw_valid = 1'b0;
        s_w        = '0;
        s_w_valid  = 1'b0;
        s_b_ready  = 1'b0;
        ddr_delays = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (!s_aw_ready || s_w_ready || s_b_valid || ddr_cmd_valid) begin
            other_errors++;
            $display("handshake outputs not in their idle state after reset");
        end
        test_aligned_incr();
        test_unaligned_short();
        test_long_split();
        test_random_delays();
        test_wrap_slverr();
        test_partial_strobes();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/ddr_port_model.sv
`timescale 1ns/100ps

module ddr_port_model (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   delay_en,
    input  ddr_wr_pkg::ddr_cmd_t   cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  ddr_wr_pkg::ddr_wdata_t wdata,
    output logic                   data_ready,
    output logic                   data_last
);
    import ddr_wr_pkg::*;

    ddr_cmd_t   cmd_q[$];       // commands in accept order
    ddr_wdata_t beat_q[$];      // beats in transfer order

    function automatic int rand_gap(input int max_gap);
        return delay_en ? int'($urandom_range(max_gap, 0)) : 0;
    endfunction

    initial begin
        int len;
        int i;
        cmd_ready  = 1'b0;
        data_ready = 1'b0;
        data_last  = 1'b0;
        forever begin
            @(negedge clk);
            if (rstn && cmd_valid) begin
                repeat (rand_gap(3)) @(negedge clk);
                cmd_ready = 1'b1;               // valid holds, handshake on the next rise
                cmd_q.push_back(cmd);
                len = cmd.len;
                @(negedge clk);
                cmd_ready = 1'b0;
                for (i = 0; i <= len; i++) begin
                    repeat (rand_gap(2)) @(negedge clk);
                    data_ready = 1'b1;
                    data_last  = (i == len);    // last comes with the final ready
                    beat_q.push_back(wdata);    // show-ahead beat, stable until the rise
                    @(negedge clk);
                    data_ready = 1'b0;
                    data_last  = 1'b0;
                end
            end
        end
    end

endmodule

// File: design/ddr3_write_bridge.sv
`timescale 1ns/100ps

module ddr3_write_bridge #(
    parameter int max_beats  = 16,
    parameter int fifo_beats = 32
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  axi_wr_pkg::axi_aw_t    s_aw,
    input  logic                   s_aw_valid,
    output logic                   s_aw_ready,
    input  axi_wr_pkg::axi_w_t     s_w,
    input  logic                   s_w_valid,
    output logic                   s_w_ready,
    output axi_wr_pkg::axi_b_t     s_b,
    output logic                   s_b_valid,
    input  logic                   s_b_ready,
    output ddr_wr_pkg::ddr_cmd_t   ddr_cmd,
    output logic                   ddr_cmd_valid,
    input  logic                   ddr_cmd_ready,
    output ddr_wr_pkg::ddr_wdata_t ddr_wdata,
    input  logic                   ddr_data_ready,
    input  logic                   ddr_data_last
);
    import axi_wr_pkg::*;

    resp_e      resp;
    logic       aw_fire;
    logic       word_push;
    logic       pad_push;
    logic       back_pad_en;
    logic       cmd_fire;
    logic       pad_front;
    logic       pad_back;
    logic       full;
    logic       final_cmd;
    logic [4:0] beats_stored;
    logic [4:0] cmd_beats;

    wr_ctrl_fsm #(.max_beats(max_beats)) u_ctrl (
        .clk, .rstn,
        .s_aw_valid, .s_aw_ready,
        .s_w_valid, .s_w_last(s_w.last), .s_w_ready,
        .s_b_valid, .s_b_ready,
        .burst(s_aw.burst), .resp,
        .aw_fire, .word_push, .pad_push, .back_pad_en, .cmd_fire,
        .pad_front, .pad_back, .full,
        .beats_stored, .cmd_beats, .final_cmd,
        .ddr_cmd_valid, .ddr_cmd_ready, .ddr_data_ready, .ddr_data_last
    );

    pad_counter u_pad (
        .clk, .rstn,
        .aw_fire, .aw(s_aw),
        .pad_push, .back_pad_en,
        .pad_front, .pad_back
    );

    burst_splitter #(.max_beats(max_beats)) u_split (
        .clk, .rstn,
        .aw_fire, .aw(s_aw),
        .cmd_fire, .cmd(ddr_cmd),
        .cmd_beats, .final_cmd
    );

    wide_pack_fifo #(.fifo_beats(fifo_beats)) u_fifo (
        .clk, .rstn,
        .word_push, .pad_push, .w(s_w),
        .full, .beats_stored,
        .rd(ddr_wdata), .pop(ddr_data_ready)  // every ready takes one beat
    );

    // single transaction in flight, the command id is the response id
    assign s_b.id   = ddr_cmd.id;
    assign s_b.resp = resp;

endmodule

// File: design/wide_pack_fifo.sv
`timescale 1ns/100ps

module wide_pack_fifo #(
    parameter int fifo_beats = 32
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   word_push,
    input  logic                   pad_push,
    input  axi_wr_pkg::axi_w_t     w,
    output logic                   full,
    output logic [4:0]             beats_stored,
    output ddr_wr_pkg::ddr_wdata_t rd,
    input  logic                   pop
);
    import ddr_wr_pkg::*;

    localparam int ptr_w = $clog2(fifo_beats);
    localparam int cnt_w = $clog2(fifo_beats + 1);

    ddr_wdata_t           mem [fifo_beats];
    ddr_wdata_t           asm_q;            // partial beat, newest word on top
    ddr_wdata_t           beat_next;
    logic [LANE_BITS-1:0] lane_q;
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic                 push;
    logic                 beat_done;
    logic                 do_pop;
    logic [31:0]          in_data;
    logic [3:0]           in_strb;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] nxt;
        nxt = (p == ptr_w'(fifo_beats - 1)) ? '0 : p + 1'b1;
        return nxt;
    endfunction

    assign push    = word_push || pad_push;
    assign in_data = pad_push ? 32'd0 : w.data;    // pad lanes carry no data
    assign in_strb = pad_push ? 4'd0 : w.strb;

    // shift right, after eight words lane 0 sits in the low bits
    assign beat_next.data = {in_data, asm_q.data[255:32]};
    assign beat_next.strb = {in_strb, asm_q.strb[31:4]};

    assign beat_done = push && (lane_q == LANE_BITS'(WORDS_PER_BEAT - 1));
    assign do_pop    = pop && (count != '0);

    // a word only needs buffer room when it closes a beat
    assign full = (count == cnt_w'(fifo_beats)) && (lane_q == LANE_BITS'(WORDS_PER_BEAT - 1));

    // saturates, no command ever waits for more than 16 beats
    assign beats_stored = (int'(count) > 31) ? 5'd31 : 5'(count);

    assign rd = mem[rd_ptr];                       // show-ahead

    always_ff @(posedge clk) begin
        if (push) begin
            asm_q <= beat_next;
        end
        if (beat_done) begin
            mem[wr_ptr] <= beat_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_q <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                lane_q <= lane_q + 1'b1;           // wraps every beat
            end
            if (beat_done) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(beat_done) - cnt_w'(do_pop);
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) pop |-> (count != '0))
        else $error("ddr_data_ready with no beat buffered");

endmodule

// File: design/burst_splitter.sv
`timescale 1ns/100ps

module burst_splitter #(
    parameter int max_beats = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 aw_fire,
    input  axi_wr_pkg::axi_aw_t  aw,
    input  logic                 cmd_fire,
    output ddr_wr_pkg::ddr_cmd_t cmd,
    output logic [4:0]           cmd_beats,
    output logic                 final_cmd
);
    import ddr_wr_pkg::*;

    logic [28:0] end_word;      // one extra bit so the top beat can't wrap
    logic [5:0]  total_beats;
    logic [27:0] addr_q;
    logic [5:0]  remain_q;      // beats not yet covered by a command
    logic [3:0]  id_q;

    assign end_word    = {1'b0, aw.addr} + 29'(aw.len);
    assign total_beats = 6'(end_word[28:LANE_BITS] - {1'b0, aw.addr[27:LANE_BITS]}) + 6'd1;

    assign cmd_beats = (remain_q > 6'(max_beats)) ? 5'(max_beats) : 5'(remain_q);
    assign final_cmd = (remain_q <= 6'(max_beats));

    assign cmd.addr = addr_q;
    assign cmd.len  = 4'(cmd_beats - 5'd1);
    assign cmd.id   = id_q;

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            addr_q <= {aw.addr[27:LANE_BITS], {LANE_BITS{1'b0}}};     // round down to beat
            id_q   <= aw.id;
        end else if (cmd_fire) begin
            addr_q <= addr_q + (28'(cmd_beats) << LANE_BITS);        // eight words per beat
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            remain_q <= '0;
        end else if (aw_fire) begin
            remain_q <= total_beats;
        end else if (cmd_fire) begin
            remain_q <= remain_q - 6'(cmd_beats);
        end
    end

    // a command issued past the end would show up here as remain_q == 0
    assert property (@(posedge clk) disable iff (!rstn)
        cmd_fire |-> (cmd.len <= 4'(max_beats - 1)) && (remain_q != '0))
        else $error("ddr command too long or issued past the transaction end");

endmodule

// File: design/pad_counter.sv
`timescale 1ns/100ps

module pad_counter (
    input  logic                clk,
    input  logic                rstn,
    input  logic                aw_fire,
    input  axi_wr_pkg::axi_aw_t aw,
    input  logic                pad_push,
    input  logic                back_pad_en,
    output logic                pad_front,
    output logic                pad_back
);
    import ddr_wr_pkg::*;

    logic [LANE_BITS-1:0] front_q;
    logic [LANE_BITS-1:0] back_q;
    logic [LANE_BITS-1:0] end_lane;

    // lane of the last word, carries above the lane bits don't matter
    assign end_lane = aw.addr[LANE_BITS-1:0] + aw.len[LANE_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            front_q <= '0;
            back_q  <= '0;
        end else if (aw_fire) begin
            front_q <= aw.addr[LANE_BITS-1:0];                          // empty lanes before word 0
            back_q  <= LANE_BITS'(WORDS_PER_BEAT - 1) - end_lane;       // empty lanes after last word
        end else if (pad_push) begin
            if (front_q != '0) begin
                front_q <= front_q - 1'b1;
            end else if (back_pad_en && (back_q != '0)) begin
                back_q <= back_q - 1'b1;
            end
        end
    end

    assign pad_front = (front_q != '0);
    assign pad_back  = (back_q != '0);

    assert property (@(posedge clk) disable iff (!rstn) pad_push |-> (pad_front || pad_back))
        else $error("pad word pushed with nothing owed");

endmodule

// File: design/wr_ctrl_fsm.sv
`timescale 1ns/100ps

module wr_ctrl_fsm #(
    parameter int max_beats = 16
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               s_aw_valid,
    output logic               s_aw_ready,
    input  logic               s_w_valid,
    input  logic               s_w_last,
    output logic               s_w_ready,
    output logic               s_b_valid,
    input  logic               s_b_ready,
    input  axi_wr_pkg::burst_e burst,
    output axi_wr_pkg::resp_e  resp,
    output logic               aw_fire,
    output logic               word_push,
    output logic               pad_push,
    output logic               back_pad_en,
    output logic               cmd_fire,
    input  logic               pad_front,
    input  logic               pad_back,
    input  logic               full,
    input  logic [4:0]         beats_stored,
    input  logic [4:0]         cmd_beats,
    input  logic               final_cmd,
    output logic               ddr_cmd_valid,
    input  logic               ddr_cmd_ready,
    input  logic               ddr_data_ready,
    input  logic               ddr_data_last
);
    import axi_wr_pkg::*;

    localparam int len_w = $clog2(max_beats);

    typedef enum logic [2:0] {
        IDLE,
        FILL,                         // pad and collect words until a command's beats are ready
        ADDR,
        DATA,
        RESP
    } wr_state_e;

    wr_state_e        state_q;
    wr_state_e        state_d;
    logic             busy;
    logic             incr_q;
    logic             last_seen_q;    // s_w last word already taken
    logic             last_cmd_q;
    logic             data_done;
    logic [len_w-1:0] beat_cnt_q;
    logic [len_w-1:0] cmd_len_q;

    assign busy        = (state_q == FILL) || (state_q == ADDR) || (state_q == DATA);
    assign s_aw_ready  = (state_q == IDLE);
    assign aw_fire     = s_aw_valid && s_aw_ready;
    assign back_pad_en = busy && last_seen_q;

    // pad words win, s_w stays stalled while any are owed
    assign pad_push  = busy && !full && (pad_front || (back_pad_en && pad_back));
    assign s_w_ready = busy && !full && !pad_front && !last_seen_q;
    assign word_push = s_w_valid && s_w_ready;

    assign ddr_cmd_valid = (state_q == ADDR);
    assign cmd_fire      = ddr_cmd_valid && ddr_cmd_ready;
    assign data_done     = (state_q == DATA) && ddr_data_ready && ddr_data_last;
    assign s_b_valid     = (state_q == RESP);
    assign resp          = incr_q ? RESP_OKAY : RESP_SLVERR;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (aw_fire) state_d = FILL;
            FILL:    if (beats_stored >= cmd_beats) state_d = ADDR;
            ADDR:    if (cmd_fire) state_d = DATA;
            DATA:    if (data_done) state_d = last_cmd_q ? RESP : FILL;
            RESP:    if (s_b_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q     <= IDLE;
            incr_q      <= 1'b1;
            last_seen_q <= 1'b0;
            last_cmd_q  <= 1'b0;
            beat_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (aw_fire) begin
                incr_q      <= (burst == BURST_INCR);   // FIXED and WRAP still go out as INCR
                last_seen_q <= 1'b0;
            end else if (word_push && s_w_last) begin
                last_seen_q <= 1'b1;
            end
            if (cmd_fire) begin
                last_cmd_q <= final_cmd;                // splitter moves on after this edge
                beat_cnt_q <= '0;
            end else if ((state_q == DATA) && ddr_data_ready) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) cmd_len_q <= len_w'(cmd_beats - 5'd1);
    end

    assert property (@(posedge clk) disable iff (!rstn) (word_push || pad_push) |-> !full)
        else $error("word written into a full pack fifo");

    assert property (@(posedge clk) disable iff (!rstn)
        ddr_cmd_valid && !ddr_cmd_ready |=> ddr_cmd_valid)
        else $error("ddr_cmd_valid dropped before ready");

    // controller must flag last on exactly the len+1-th beat
    assert property (@(posedge clk) disable iff (!rstn) data_done |-> beat_cnt_q == cmd_len_q)
        else $error("ddr_data_last out of step with command length");

endmodule

// File: design/ddr_wr_pkg.sv
package ddr_wr_pkg;

    // 32-bit words per 256-bit controller beat
    localparam int WORDS_PER_BEAT = 8;

    // address bits that pick a word lane inside a beat
    localparam int LANE_BITS = 3;

    // write command to the DDR3 controller
    typedef struct packed {
        logic [27:0] addr;       // word units, beat aligned
        logic [3:0]  len;        // beats minus one
        logic [3:0]  id;
    } ddr_cmd_t;

    // one wide data beat, lane 0 in the low bits
    typedef struct packed {
        logic [255:0] data;
        logic [31:0]  strb;
    } ddr_wdata_t;

endpackage

// File: design/axi_wr_pkg.sv
package axi_wr_pkg;

    // AXI burst encoding, only INCR maps onto DDR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // write address request
    typedef struct packed {
        logic [3:0]  id;
        logic [27:0] addr;       // word units
        logic [7:0]  len;        // words minus one
        burst_e      burst;
    } axi_aw_t;

    // one write data word
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;       // byte enables
        logic        last;
    } axi_w_t;

    // write response
    typedef struct packed {
        logic [3:0] id;
        resp_e      resp;
    } axi_b_t;

endpackage
